// File: Bender.yml
package:
  name: udp_tx

sources:
  - design/udp_tx_pkg.sv
  - design/mii_tick_gen.sv
  - design/udp_frame_builder.sv
  - design/crc32_nibble.sv
  - design/mii_tx_sequencer.sv
  - design/udp_tx_top.sv
  - target: test
    files:
      - test/udp_tx_properties.sv
      - test/udp_tx_tb.sv

// File: design/crc32_nibble.sv
`timescale 1ns/100ps
`default_nettype none

module crc32_nibble (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        crc_clear,
    input  wire logic        crc_enable,
    input  wire logic [3:0]  crc_nibble,
    output logic      [31:0] crc_value
);

    logic [31:0] crc_reg;

    // Four reflected bit steps, data LSB first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [3:0] nib);
        logic [31:0] c;
        c = crc ^ {28'h0, nib};
        for (int i = 0; i < 4; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ udp_tx_pkg::crc32_poly_reflected;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Seeded with all ones at the start of every frame
    always_ff @(posedge clk) begin
        if (reset || crc_clear) begin
            crc_reg <= 32'hFFFF_FFFF;
        end else if (crc_enable) begin
            crc_reg <= crc_step(crc_reg, crc_nibble);
        end
    end

    // Final complement gives the FCS, low byte goes out first
    assign crc_value = ~crc_reg;

endmodule

`default_nettype wire

// File: design/mii_tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

module mii_tick_gen #(
    parameter int DIVIDER = 4
) (
    input  wire logic clk,
    input  wire logic reset,
    output logic      tick
);

    localparam int cnt_width = $clog2(DIVIDER);
    localparam logic [cnt_width-1:0] cnt_last = cnt_width'(DIVIDER - 1);

    logic [cnt_width-1:0] count;

    // Free running count, tick registered on the wrap
    // First tick lands DIVIDER cycles after reset drops
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (count == cnt_last);
            if (count == cnt_last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mii_tx_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module mii_tx_sequencer #(
    parameter int DATA_BYTES = 18
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        tick,
    input  wire logic        req,
    output logic             ack,
    output logic             load,
    output logic [$clog2(udp_tx_pkg::eth_header_bytes + udp_tx_pkg::ip_header_bytes
                         + udp_tx_pkg::udp_header_bytes + DATA_BYTES)-1:0] byte_index,
    input  wire logic [7:0]  frame_byte,
    output logic             crc_clear,
    output logic             crc_enable,
    output logic [3:0]       crc_nibble,
    input  wire logic [31:0] crc_value,
    output logic             tx_en,
    output logic [3:0]       tx_d
);

    // Frame bytes from the Ethernet header through the payload
    localparam int frame_bytes = udp_tx_pkg::eth_header_bytes + udp_tx_pkg::ip_header_bytes
        + udp_tx_pkg::udp_header_bytes + DATA_BYTES;
    localparam int cnt_width = $clog2(frame_bytes);

    // End values of the shared counter in each state
    localparam logic [cnt_width-1:0] preamble_last = cnt_width'(2 * udp_tx_pkg::preamble_sfd_bytes - 1);
    localparam logic [cnt_width-1:0] frame_last = cnt_width'(frame_bytes - 1);
    localparam logic [cnt_width-1:0] fcs_last = cnt_width'(2 * udp_tx_pkg::fcs_bytes - 1);
    localparam logic [cnt_width-1:0] gap_last = cnt_width'(udp_tx_pkg::gap_nibbles);

    // State codes
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_preamble = 3'd1;
    localparam logic [2:0] st_frame = 3'd2;
    localparam logic [2:0] st_fcs = 3'd3;
    localparam logic [2:0] st_gap = 3'd4;
    localparam logic [2:0] st_done = 3'd5;

    logic [2:0]           state;
    logic [cnt_width-1:0] cnt;
    // High half of the current byte when set
    logic                 nib_hi;
    logic [3:0]           frame_nib;

    // Capture pulse, also restarts the CRC
    assign load = (state == st_idle) && req && !ack;
    assign crc_clear = load;

    // Counter doubles as the byte index while in the frame state
    assign byte_index = cnt;
    assign frame_nib = nib_hi ? frame_byte[7:4] : frame_byte[3:0];

    // CRC sees each frame nibble on the tick that sends it
    assign crc_enable = (state == st_frame) && tick;
    assign crc_nibble = frame_nib;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            cnt <= '0;
            nib_hi <= 1'b0;
            tx_en <= 1'b0;
            tx_d <= 4'h0;
            ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (load) begin
                        cnt <= '0;
                        nib_hi <= 1'b0;
                        state <= st_preamble;
                    end
                end
                // Sixteen nibbles of preamble and SFD
                st_preamble: begin
                    if (tick) begin
                        tx_en <= 1'b1;
                        tx_d <= udp_tx_pkg::preamble_sfd[4*cnt +: 4];
                        if (cnt == preamble_last) begin
                            cnt <= '0;
                            state <= st_frame;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                // Headers and payload, low nibble of each byte first
                st_frame: begin
                    if (tick) begin
                        tx_d <= frame_nib;
                        nib_hi <= !nib_hi;
                        if (nib_hi) begin
                            if (cnt == frame_last) begin
                                cnt <= '0;
                                state <= st_fcs;
                            end else begin
                                cnt <= cnt + 1'b1;
                            end
                        end
                    end
                end
                // FCS from the low nibble up, CRC is frozen by now
                st_fcs: begin
                    if (tick) begin
                        tx_d <= crc_value[4*cnt +: 4];
                        if (cnt == fcs_last) begin
                            cnt <= '0;
                            state <= st_gap;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                // First tick ends the last FCS nibble, then 24 gap ticks
                st_gap: begin
                    if (tick) begin
                        tx_en <= 1'b0;
                        tx_d <= 4'h0;
                        if (cnt == gap_last) begin
                            cnt <= '0;
                            ack <= 1'b1;
                            state <= st_done;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                // Hold ack until the requester lets go
                st_done: begin
                    if (!req) begin
                        ack <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/udp_frame_builder.sv
`timescale 1ns/100ps
`default_nettype none

module udp_frame_builder #(
    parameter int DATA_BYTES = 18
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    load,
    input  wire udp_tx_pkg::mac_addr_t   dest_mac,
    input  wire udp_tx_pkg::mac_addr_t   src_mac,
    input  wire udp_tx_pkg::ip_addr_t    dest_ip,
    input  wire udp_tx_pkg::ip_addr_t    src_ip,
    input  wire udp_tx_pkg::udp_port_t   dest_port,
    input  wire udp_tx_pkg::udp_port_t   src_port,
    input  wire logic [8*DATA_BYTES-1:0] payload,
    input  wire logic [$clog2(udp_tx_pkg::eth_header_bytes + udp_tx_pkg::ip_header_bytes
                              + udp_tx_pkg::udp_header_bytes + DATA_BYTES)-1:0] byte_index,
    output logic [7:0]                   frame_byte
);

    // Ethernet, IP and UDP headers back to back
    localparam int header_bytes = udp_tx_pkg::eth_header_bytes
        + udp_tx_pkg::ip_header_bytes + udp_tx_pkg::udp_header_bytes;
    localparam int frame_bytes = header_bytes + DATA_BYTES;

    // Length fields are fixed by the payload size
    localparam logic [15:0] udp_length = 16'(udp_tx_pkg::udp_header_bytes + DATA_BYTES);
    localparam logic [15:0] ip_total_length = 16'(udp_tx_pkg::ip_header_bytes
        + udp_tx_pkg::udp_header_bytes + DATA_BYTES);

    udp_tx_pkg::mac_addr_t   dest_mac_q;
    udp_tx_pkg::mac_addr_t   src_mac_q;
    udp_tx_pkg::ip_header_u  ip_hdr;
    udp_tx_pkg::udp_port_t   dest_port_q;
    udp_tx_pkg::udp_port_t   src_port_q;
    logic [8*DATA_BYTES-1:0] payload_q;
    logic                    csum_pending;
    logic [15:0]             ip_csum;
    logic [8*header_bytes-1:0] header_bits;

    // Checksum write happens one cycle after the capture
    always_ff @(posedge clk) begin
        if (reset) begin
            csum_pending <= 1'b0;
        end else begin
            csum_pending <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dest_mac_q <= dest_mac;
            src_mac_q <= src_mac;
            dest_port_q <= dest_port;
            src_port_q <= src_port;
            payload_q <= payload;
            ip_hdr.fields.version <= udp_tx_pkg::ip_version;
            ip_hdr.fields.ihl <= udp_tx_pkg::ip_ihl;
            ip_hdr.fields.type_of_service <= udp_tx_pkg::ip_tos;
            ip_hdr.fields.total_length <= ip_total_length;
            ip_hdr.fields.identification <= '0;
            ip_hdr.fields.flags <= '0;
            ip_hdr.fields.fragment_offset <= '0;
            ip_hdr.fields.time_to_live <= udp_tx_pkg::ip_ttl;
            ip_hdr.fields.protocol <= udp_tx_pkg::ip_protocol_udp;
            // Zero while the sum is formed
            ip_hdr.fields.header_checksum <= '0;
            ip_hdr.fields.src_ip <= src_ip;
            ip_hdr.fields.dest_ip <= dest_ip;
        end else if (csum_pending) begin
            ip_hdr.fields.header_checksum <= ip_csum;
        end
    end

    // Ones' complement sum over the ten header words
    always_comb begin : csum_calc
        logic [19:0] acc;
        logic [16:0] fold;
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + 20'(ip_hdr.words[i]);
        end
        // Two folds are enough for ten words
        fold = 17'(acc[15:0]) + 17'(acc[19:16]);
        ip_csum = ~(fold[15:0] + 16'(fold[16]));
    end

    // Header in wire order, byte 0 at the top, UDP checksum left at zero
    assign header_bits = {dest_mac_q, src_mac_q, udp_tx_pkg::ether_type_ipv4, ip_hdr,
                          src_port_q, dest_port_q, udp_length, 16'h0000};

    // Header bytes from the top down, payload byte 0 from the bottom up
    always_comb begin : byte_mux
        int idx;
        idx = int'(byte_index);
        if (idx < header_bytes) begin
            frame_byte = header_bits[8*(header_bytes-1-idx) +: 8];
        end else if (idx < frame_bytes) begin
            frame_byte = payload_q[8*(idx-header_bytes) +: 8];
        end else begin
            frame_byte = 8'h00;
        end
    end

endmodule

`default_nettype wire

// File: design/udp_tx_pkg.sv
`default_nettype none

package udp_tx_pkg;

    // Byte counts of the frame sections
    localparam int unsigned preamble_sfd_bytes = 8;
    localparam int unsigned eth_header_bytes = 14;
    localparam int unsigned ip_header_bytes = 20;
    localparam int unsigned udp_header_bytes = 8;
    localparam int unsigned fcs_bytes = 4;

    // Interframe gap in nibble times
    localparam int unsigned gap_nibbles = 24;

    // Seven 0x55 bytes then the SFD
    // Byte 0 sits in the low 8 bits and goes out first
    localparam logic [63:0] preamble_sfd = 64'hD5_55_55_55_55_55_55_55;

    // EtherType for IPv4
    localparam logic [15:0] ether_type_ipv4 = 16'h0800;

    // Fixed IPv4 header fields
    localparam logic [3:0] ip_version = 4'd4;
    localparam logic [3:0] ip_ihl = 4'd5;
    // High throughput and reliability
    localparam logic [7:0] ip_tos = 8'h0C;
    localparam logic [7:0] ip_ttl = 8'hFF;
    localparam logic [7:0] ip_protocol_udp = 8'h11;

    // Ethernet CRC-32, bit reversed form of 0x04C11DB7
    localparam logic [31:0] crc32_poly_reflected = 32'hEDB88320;

    // Register value left after running the CRC over a frame and its own FCS
    localparam logic [31:0] crc32_residue = 32'hDEBB20E3;

    // Address and port vectors
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // IPv4 header fields in RFC 791 order
    // First field on the wire sits at the top bits
    typedef struct packed {
        logic [3:0] version;
        logic [3:0] ihl;
        logic [7:0] type_of_service;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0] flags;
        logic [12:0] fragment_offset;
        logic [7:0] time_to_live;
        logic [7:0] protocol;
        logic [15:0] header_checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ip_header_fields_t;

    // Same 160 bits seen as named fields or as ten checksum words
    // Word 9 holds version, IHL and TOS
    typedef union packed {
        ip_header_fields_t fields;
        logic [9:0][15:0] words;
    } ip_header_u;

endpackage

`default_nettype wire

// File: design/udp_tx_top.sv
`timescale 1ns/100ps
`default_nettype none

module udp_tx_top #(
    parameter int DATA_BYTES = 18,
    parameter int DIVIDER = 4
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    req,
    output logic                         ack,
    input  wire udp_tx_pkg::mac_addr_t   dest_mac,
    input  wire udp_tx_pkg::mac_addr_t   src_mac,
    input  wire udp_tx_pkg::ip_addr_t    dest_ip,
    input  wire udp_tx_pkg::ip_addr_t    src_ip,
    input  wire udp_tx_pkg::udp_port_t   dest_port,
    input  wire udp_tx_pkg::udp_port_t   src_port,
    input  wire logic [8*DATA_BYTES-1:0] payload,
    output logic                         tx_en,
    output logic [3:0]                   tx_d
);

    localparam int frame_bytes = udp_tx_pkg::eth_header_bytes + udp_tx_pkg::ip_header_bytes
        + udp_tx_pkg::udp_header_bytes + DATA_BYTES;
    localparam int index_width = $clog2(frame_bytes);

    // Payload must reach the Ethernet minimum and fit a 576 byte datagram
    if (DATA_BYTES < 18 || DATA_BYTES > 508) begin : g_bad_data_bytes
        $error("DATA_BYTES is %0d, it must lie from 18 to 508", DATA_BYTES);
    end

    // Nibble tick needs at least two clocks
    if (DIVIDER < 2) begin : g_bad_divider
        $error("DIVIDER is %0d, it must be at least 2", DIVIDER);
    end

    logic                   tick;
    logic                   load;
    logic [index_width-1:0] byte_index;
    logic [7:0]             frame_byte;
    logic                   crc_clear;
    logic                   crc_enable;
    logic [3:0]             crc_nibble;
    logic [31:0]            crc_value;

    mii_tick_gen #(
        .DIVIDER(DIVIDER)
    ) u_tick_gen (
        .clk(clk),
        .reset(reset),
        .tick(tick)
    );

    udp_frame_builder #(
        .DATA_BYTES(DATA_BYTES)
    ) u_builder (
        .clk(clk),
        .reset(reset),
        .load(load),
        .dest_mac(dest_mac),
        .src_mac(src_mac),
        .dest_ip(dest_ip),
        .src_ip(src_ip),
        .dest_port(dest_port),
        .src_port(src_port),
        .payload(payload),
        .byte_index(byte_index),
        .frame_byte(frame_byte)
    );

    mii_tx_sequencer #(
        .DATA_BYTES(DATA_BYTES)
    ) u_sequencer (
        .clk(clk),
        .reset(reset),
        .tick(tick),
        .req(req),
        .ack(ack),
        .load(load),
        .byte_index(byte_index),
        .frame_byte(frame_byte),
        .crc_clear(crc_clear),
        .crc_enable(crc_enable),
        .crc_nibble(crc_nibble),
        .crc_value(crc_value),
        .tx_en(tx_en),
        .tx_d(tx_d)
    );

    crc32_nibble u_crc (
        .clk(clk),
        .reset(reset),
        .crc_clear(crc_clear),
        .crc_enable(crc_enable),
        .crc_nibble(crc_nibble),
        .crc_value(crc_value)
    );

endmodule

`default_nettype wire

// File: files.f
design/udp_tx_pkg.sv
design/mii_tick_gen.sv
design/udp_frame_builder.sv
design/crc32_nibble.sv
design/mii_tx_sequencer.sv
design/udp_tx_top.sv
test/udp_tx_properties.sv
test/udp_tx_tb.sv

// File: test/udp_tx_properties.sv
`timescale 1ns/100ps
`default_nettype none

module udp_tx_properties (
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       tick,
    input wire logic       req,
    input wire logic       ack,
    input wire logic       load,
    input wire logic       tx_en,
    input wire logic [3:0] tx_d
);

    // MII outputs only move on a nibble tick
    assert property (@(posedge clk) disable iff (reset)
        !tick |=> $stable(tx_d) && $stable(tx_en))
        else $error("tx_d or tx_en changed outside a tick cycle");

    // Ack belongs to the idle side of the frame
    assert property (@(posedge clk) disable iff (reset) !(ack && tx_en))
        else $error("ack and tx_en high together");

    // Capture needs an open request and a quiet line
    assert property (@(posedge clk) disable iff (reset) load |-> req && !ack && !tx_en)
        else $error("load without req high, ack low and tx_en low");

    assert property (@(posedge clk) disable iff (reset) load |=> !load)
        else $error("load held longer than one cycle");

endmodule

bind mii_tx_sequencer udp_tx_properties u_props (
    .clk(clk),
    .reset(reset),
    .tick(tick),
    .req(req),
    .ack(ack),
    .load(load),
    .tx_en(tx_en),
    .tx_d(tx_d)
);

`default_nettype wire

// File: test/udp_tx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module udp_tx_tb;

    localparam int data_bytes = 18;
    localparam int divider = 4;
    // Bytes on the wire, preamble through FCS
    localparam int total_bytes = udp_tx_pkg::preamble_sfd_bytes + udp_tx_pkg::eth_header_bytes
        + udp_tx_pkg::ip_header_bytes + udp_tx_pkg::udp_header_bytes + data_bytes
        + udp_tx_pkg::fcs_bytes;
    localparam int ip_pos = udp_tx_pkg::preamble_sfd_bytes + udp_tx_pkg::eth_header_bytes;
    localparam int udp_pos = ip_pos + udp_tx_pkg::ip_header_bytes;
    localparam int payload_pos = udp_pos + udp_tx_pkg::udp_header_bytes;
    localparam int fcs_pos = payload_pos + data_bytes;
    localparam int frame_nibbles = 16 + 2 * (46 + data_bytes);
    // Eight frames with slack, plus setup
    localparam int cycle_limit = 8 * (16 + 2 * 64 + 24 + 8) * divider + 200;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    req;
    logic                    ack;
    udp_tx_pkg::mac_addr_t   dest_mac;
    udp_tx_pkg::mac_addr_t   src_mac;
    udp_tx_pkg::ip_addr_t    dest_ip;
    udp_tx_pkg::ip_addr_t    src_ip;
    udp_tx_pkg::udp_port_t   dest_port;
    udp_tx_pkg::udp_port_t   src_port;
    logic [8*data_bytes-1:0] payload;
    logic                    tx_en;
    logic [3:0]              tx_d;

    logic [7:0]  exp_bytes [0:total_bytes-1];
    logic [7:0]  got_bytes [0:total_bytes-1];
    logic [15:0] exp_csum;
    int          got_nibbles;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          cycle_count = 0;

    udp_tx_top #(
        .DATA_BYTES(data_bytes),
        .DIVIDER(divider)
    ) uut (
        .clk(clk),
        .reset(reset),
        .req(req),
        .ack(ack),
        .dest_mac(dest_mac),
        .src_mac(src_mac),
        .dest_ip(dest_ip),
        .src_ip(src_ip),
        .dest_port(dest_port),
        .src_port(src_port),
        .payload(payload),
        .tx_en(tx_en),
        .tx_d(tx_d)
    );

    always #5 clk = ~clk;

    // Hard stop if the DUT never finishes
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    // Reflected CRC-32, one byte LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

    // Big-endian 16-bit field
    function automatic void put_word(input int pos, input logic [15:0] w);
        exp_bytes[pos] = w[15:8];
        exp_bytes[pos + 1] = w[7:0];
    endfunction

    // Expected wire bytes for one request
    function automatic void build_expected(
        input udp_tx_pkg::mac_addr_t dm, input udp_tx_pkg::mac_addr_t sm,
        input udp_tx_pkg::ip_addr_t di, input udp_tx_pkg::ip_addr_t si,
        input udp_tx_pkg::udp_port_t dp, input udp_tx_pkg::udp_port_t sp,
        input logic [8*data_bytes-1:0] pl);
        logic [31:0] sum;
        logic [31:0] crc;
        for (int i = 0; i < 7; i++) begin
            exp_bytes[i] = 8'h55;
        end
        exp_bytes[7] = 8'hD5;
        // Ethernet header
        for (int i = 0; i < 6; i++) begin
            exp_bytes[8 + i] = dm[47 - 8*i -: 8];
            exp_bytes[14 + i] = sm[47 - 8*i -: 8];
        end
        put_word(20, udp_tx_pkg::ether_type_ipv4);
        // IPv4 header, checksum zero for the sum
        exp_bytes[ip_pos] = {udp_tx_pkg::ip_version, udp_tx_pkg::ip_ihl};
        exp_bytes[ip_pos + 1] = udp_tx_pkg::ip_tos;
        put_word(ip_pos + 2, 16'(28 + data_bytes));
        put_word(ip_pos + 4, 16'h0000);
        put_word(ip_pos + 6, 16'h0000);
        exp_bytes[ip_pos + 8] = udp_tx_pkg::ip_ttl;
        exp_bytes[ip_pos + 9] = udp_tx_pkg::ip_protocol_udp;
        put_word(ip_pos + 10, 16'h0000);
        put_word(ip_pos + 12, si[31:16]);
        put_word(ip_pos + 14, si[15:0]);
        put_word(ip_pos + 16, di[31:16]);
        put_word(ip_pos + 18, di[15:0]);
        sum = 0;
        for (int w = 0; w < 10; w++) begin
            sum = sum + {exp_bytes[ip_pos + 2*w], exp_bytes[ip_pos + 2*w + 1]};
        end
        while (sum[31:16] != 0) begin
            sum = sum[15:0] + sum[31:16];
        end
        exp_csum = ~sum[15:0];
        put_word(ip_pos + 10, exp_csum);
        // UDP header, checksum left at zero
        put_word(udp_pos, sp);
        put_word(udp_pos + 2, dp);
        put_word(udp_pos + 4, 16'(8 + data_bytes));
        put_word(udp_pos + 6, 16'h0000);
        for (int i = 0; i < data_bytes; i++) begin
            exp_bytes[payload_pos + i] = pl[8*i +: 8];
        end
        // FCS over everything after the SFD, low byte first
        crc = 32'hFFFF_FFFF;
        for (int i = 8; i < fcs_pos; i++) begin
            crc = crc_byte(crc, exp_bytes[i]);
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            exp_bytes[fcs_pos + k] = crc[8*k +: 8];
        end
    endfunction

    function automatic logic [8*data_bytes-1:0] counting_payload(input logic [7:0] start);
        logic [8*data_bytes-1:0] pl;
        for (int i = 0; i < data_bytes; i++) begin
            pl[8*i +: 8] = start + 8'(i);
        end
        return pl;
    endfunction

    task automatic start_request(
        input udp_tx_pkg::mac_addr_t dm, input udp_tx_pkg::mac_addr_t sm,
        input udp_tx_pkg::ip_addr_t di, input udp_tx_pkg::ip_addr_t si,
        input udp_tx_pkg::udp_port_t dp, input udp_tx_pkg::udp_port_t sp,
        input logic [8*data_bytes-1:0] pl);
        @(posedge clk);
        #1;
        dest_mac = dm;
        src_mac = sm;
        dest_ip = di;
        src_ip = si;
        dest_port = dp;
        src_port = sp;
        payload = pl;
        req = 1'b1;
        build_expected(dm, sm, di, si, dp, sp, pl);
    endtask

    // Mid-nibble sampling on falling edges, low nibble first
    task automatic capture_frame();
        int n;
        n = 0;
        do begin
            @(negedge clk);
        end while (!tx_en);
        while (tx_en) begin
            if (n / 2 < total_bytes) begin
                if (n % 2 == 0) begin
                    got_bytes[n / 2][3:0] = tx_d;
                end else begin
                    got_bytes[n / 2][7:4] = tx_d;
                end
            end
            check_value("ack during frame", ack, 0);
            n++;
            repeat (divider) @(negedge clk);
        end
        got_nibbles = n;
    endtask

    // Entered on the first falling edge after tx_en drops
    task automatic wait_for_ack();
        int n;
        n = 0;
        while (!ack) begin
            check_value("tx_en in gap", tx_en, 0);
            @(negedge clk);
            n++;
        end
        check_value("gap cycles before ack", n, udp_tx_pkg::gap_nibbles * divider);
    endtask

    task automatic release_request();
        @(posedge clk);
        #1;
        req = 1'b0;
        @(negedge clk);
        check_value("ack before req is seen low", ack, 1);
        @(negedge clk);
        check_value("ack after req drop", ack, 0);
    endtask

    task automatic run_frame(
        input udp_tx_pkg::mac_addr_t dm, input udp_tx_pkg::mac_addr_t sm,
        input udp_tx_pkg::ip_addr_t di, input udp_tx_pkg::ip_addr_t si,
        input udp_tx_pkg::udp_port_t dp, input udp_tx_pkg::udp_port_t sp,
        input logic [8*data_bytes-1:0] pl);
        start_request(dm, sm, di, si, dp, sp, pl);
        capture_frame();
        wait_for_ack();
        release_request();
    endtask

    task automatic compare_bytes(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            check_value($sformatf("frame byte %0d", i), got_bytes[i], exp_bytes[i]);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("Test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("tx_en", tx_en, 0);
            check_value("tx_d", tx_d, 0);
            check_value("ack", ack, 0);
        end
        finish_test("reset_state", errs);
    endtask

    task automatic test_fixed_headers();
        int errs;
        errs = error_count;
        run_frame(48'h0200_0000_0001, 48'h0200_0000_00FE, 32'hC0A8_0001, 32'hC0A8_0064,
                  16'd5000, 16'd4000, counting_payload(8'h00));
        compare_bytes(0, payload_pos - 1);
        check_value("ip total length", {got_bytes[ip_pos + 2], got_bytes[ip_pos + 3]},
                    28 + data_bytes);
        check_value("udp length", {got_bytes[udp_pos + 4], got_bytes[udp_pos + 5]},
                    8 + data_bytes);
        finish_test("fixed_headers", errs);
    endtask

    task automatic test_ip_checksum();
        int errs;
        logic [31:0] sum;
        errs = error_count;
        run_frame(48'hFFFF_FFFF_FFFF, 48'h0A1B_2C3D_4E5F, 32'hFFFF_FFFF, 32'h0A00_00FE,
                  16'hFFFF, 16'h0035, counting_payload(8'hF0));
        check_value("ip header checksum",
                    {got_bytes[ip_pos + 10], got_bytes[ip_pos + 11]}, exp_csum);
        // Ones' complement sum of a valid header is all ones
        sum = 0;
        for (int w = 0; w < 10; w++) begin
            sum = sum + {got_bytes[ip_pos + 2*w], got_bytes[ip_pos + 2*w + 1]};
        end
        while (sum[31:16] != 0) begin
            sum = sum[15:0] + sum[31:16];
        end
        check_value("ip header word sum", sum, 32'h0000_FFFF);
        finish_test("ip_checksum", errs);
    endtask

    task automatic test_payload_fcs();
        int errs;
        logic [31:0] crc;
        errs = error_count;
        run_frame(48'h0011_2233_4455, 48'h6677_8899_AABB, 32'h0102_0304, 32'h0506_0708,
                  16'd1234, 16'd80, counting_payload(8'h5A));
        compare_bytes(payload_pos, total_bytes - 1);
        check_value("nibble count", got_nibbles, frame_nibbles);
        // Frame plus its own FCS leaves the fixed residue
        crc = 32'hFFFF_FFFF;
        for (int i = 8; i < total_bytes; i++) begin
            crc = crc_byte(crc, got_bytes[i]);
        end
        check_value("crc residue", crc, udp_tx_pkg::crc32_residue);
        finish_test("payload_fcs", errs);
    endtask

    task automatic test_handshake();
        int errs;
        errs = error_count;
        start_request(48'h0200_0000_0005, 48'h0200_0000_0006, 32'h0A00_0005, 32'h0A00_0006,
                      16'd7, 16'd9, counting_payload(8'h80));
        capture_frame();
        wait_for_ack();
        compare_bytes(0, total_bytes - 1);
        // Req still high, no second frame may start
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("ack with req held", ack, 1);
            check_value("tx_en with req held", tx_en, 0);
        end
        release_request();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("tx_en after release", tx_en, 0);
        end
        finish_test("handshake", errs);
    endtask

    task automatic test_random_frames();
        int errs;
        udp_tx_pkg::mac_addr_t dm;
        udp_tx_pkg::mac_addr_t sm;
        udp_tx_pkg::ip_addr_t di;
        udp_tx_pkg::ip_addr_t si;
        udp_tx_pkg::udp_port_t dp;
        udp_tx_pkg::udp_port_t sp;
        logic [8*data_bytes-1:0] pl;
        errs = error_count;
        for (int f = 0; f < 4; f++) begin
            dm = {16'($urandom), $urandom};
            sm = {16'($urandom), $urandom};
            di = $urandom;
            si = $urandom;
            dp = 16'($urandom);
            sp = 16'($urandom);
            for (int i = 0; i < data_bytes; i++) begin
                pl[8*i +: 8] = 8'($urandom);
            end
            run_frame(dm, sm, di, si, dp, sp, pl);
            compare_bytes(0, total_bytes - 1);
            check_value("nibble count", got_nibbles, frame_nibbles);
        end
        finish_test("random_frames", errs);
    endtask

    initial begin
        void'($urandom(32'hbf9e_9b1d));
        reset = 1'b1;
        req = 1'b0;
        dest_mac = '0;
        src_mac = '0;
        dest_ip = '0;
        src_ip = '0;
        dest_port = '0;
        src_port = '0;
        payload = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_fixed_headers();
        test_ip_checksum();
        test_payload_fcs();
        test_handshake();
        test_random_frames();
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
